//--- verilog/lsq_isa_pkg.sv
package lsq_isa_pkg;

    typedef logic [2:0]  funct3_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  byte_mask_t;

    // load funct3 codes
    localparam funct3_t F3_LB  = 3'b000;
    localparam funct3_t F3_LH  = 3'b001;
    localparam funct3_t F3_LW  = 3'b010;
    localparam funct3_t F3_LBU = 3'b100;
    localparam funct3_t F3_LHU = 3'b101;

    // store funct3 codes
    localparam funct3_t F3_SB  = 3'b000;
    localparam funct3_t F3_SH  = 3'b001;
    localparam funct3_t F3_SW  = 3'b010;

endpackage : lsq_isa_pkg

//--- verilog/lsq_cfg_pkg.sv
package lsq_cfg_pkg;

    // queue depths
    localparam int SQ_DEPTH = 8;
    localparam int LQ_DEPTH = 8;

    localparam int SQ_IDX_W = $clog2(SQ_DEPTH);
    localparam int LQ_IDX_W = $clog2(LQ_DEPTH);

    // slot indices
    typedef logic [SQ_IDX_W-1:0] sq_idx_t;
    typedef logic [LQ_IDX_W-1:0] lq_idx_t;

    // one extra bit so a full queue can be told from an empty one
    typedef logic [SQ_IDX_W:0] sq_count_t;

    // tags from rename and the rob
    typedef logic [4:0] rob_idx_t;
    typedef logic [5:0] phys_reg_t;
    typedef logic [4:0] arch_reg_t;

endpackage : lsq_cfg_pkg

//--- verilog/load_result_format.sv
module load_result_format
    import lsq_isa_pkg::*;
(
    input  funct3_t    funct3,
    input  logic [1:0] offset,
    input  word_t      raw,
    output word_t      value
);

    logic [7:0]  byte_sel;
    logic [15:0] half_sel;

    // pick the addressed lane
    assign byte_sel = raw[{offset, 3'b000} +: 8];
    assign half_sel = raw[{offset[1], 4'b0000} +: 16];

    always_comb
    begin
        case (funct3)
            F3_LB:   value = {{24{byte_sel[7]}}, byte_sel};
            F3_LBU:  value = {24'b0, byte_sel};
            F3_LH:   value = {{16{half_sel[15]}}, half_sel};
            F3_LHU:  value = {16'b0, half_sel};
            F3_LW:   value = raw;
            default: value = '0;
        endcase
    end

endmodule : load_result_format

//--- verilog/store_queue.sv
module store_queue
    import lsq_isa_pkg::*;
    import lsq_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       st_dispatch,
    input  funct3_t    funct3,
    input  rob_idx_t   rob_idx,
    input  logic       addr_valid,
    input  logic       addr_is_store,
    input  sq_idx_t    slot,
    input  word_t      addr,
    input  word_t      wdata,
    input  rob_idx_t   commit_rob,
    input  logic       st_grant,
    input  logic       st_done,
    output sq_idx_t    st_slot,
    output sq_count_t  st_count,
    output logic       st_full,
    output logic       st_req,
    output word_t      st_addr,
    output byte_mask_t st_wmask,
    output word_t      st_wdata,
    output rob_idx_t   st_done_rob
);

    // pointers with wrap bit
    sq_count_t           head;
    sq_count_t           tail;
    logic [SQ_DEPTH-1:0] addr_rdy;
    // head entry already handed to the cache
    logic                issued;

    funct3_t  f3_mem   [SQ_DEPTH];
    rob_idx_t rob_mem  [SQ_DEPTH];
    word_t    addr_mem [SQ_DEPTH];
    word_t    data_mem [SQ_DEPTH];

    sq_idx_t    head_idx;
    logic [1:0] off;
    word_t      head_data;

    assign head_idx = head[SQ_IDX_W-1:0];
    assign st_slot  = tail[SQ_IDX_W-1:0];
    assign st_count = tail - head;
    assign st_full  = (st_count == sq_count_t'(SQ_DEPTH));

    // only the committing head may go out
    assign st_req = (st_count != '0) && addr_rdy[head_idx] && !issued
                    && (rob_mem[head_idx] == commit_rob);

    assign st_addr     = addr_mem[head_idx];
    assign st_done_rob = rob_mem[head_idx];
    assign off         = st_addr[1:0];
    assign head_data   = data_mem[head_idx];

    // byte lanes and data placement
    always_comb
    begin
        case (f3_mem[head_idx])
            F3_SB:
            begin
                st_wmask = 4'b0001 << off;
                st_wdata = word_t'(head_data[7:0]) << {off, 3'b000};
            end
            F3_SH:
            begin
                st_wmask = 4'b0011 << {off[1], 1'b0};
                st_wdata = word_t'(head_data[15:0]) << {off[1], 4'b0000};
            end
            F3_SW:
            begin
                st_wmask = 4'b1111;
                st_wdata = head_data;
            end
            default:
            begin
                st_wmask = 4'b0000;
                st_wdata = '0;
            end
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            head     <= '0;
            tail     <= '0;
            addr_rdy <= '0;
            issued   <= 1'b0;
        end
        else
        begin
            if (st_dispatch && !st_full)
            begin
                tail              <= tail + 1'b1;
                addr_rdy[st_slot] <= 1'b0;
            end
            if (addr_valid && addr_is_store)
                addr_rdy[slot] <= 1'b1;
            if (st_grant)
                issued <= 1'b1;
            if (st_done)
            begin
                head   <= head + 1'b1;
                issued <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        if (st_dispatch && !st_full)
        begin
            f3_mem[st_slot]  <= funct3;
            rob_mem[st_slot] <= rob_idx;
        end
        if (addr_valid && addr_is_store)
        begin
            addr_mem[slot] <= addr;
            data_mem[slot] <= wdata;
        end
    end

endmodule : store_queue

//--- verilog/load_queue.sv
module load_queue
    import lsq_isa_pkg::*;
    import lsq_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       ld_dispatch,
    input  funct3_t    funct3,
    input  rob_idx_t   rob_idx,
    input  phys_reg_t  pd,
    input  arch_reg_t  rd,
    input  sq_count_t  st_count,
    input  logic       addr_valid,
    input  logic       addr_is_store,
    input  lq_idx_t    slot,
    input  word_t      addr,
    input  logic       ld_grant,
    input  logic       ld_done,
    input  logic       st_done,
    input  word_t      d_rdata,
    output lq_idx_t    ld_slot,
    output logic       ld_full,
    output logic       ld_req,
    output word_t      ld_addr,
    output byte_mask_t ld_rmask,
    output rob_idx_t   ld_done_rob,
    output phys_reg_t  ld_done_pd,
    output arch_reg_t  ld_done_rd,
    output word_t      ld_value
);

    logic [LQ_DEPTH-1:0] valid;
    logic [LQ_DEPTH-1:0] addr_rdy;
    logic [LQ_DEPTH-1:0] ready;
    logic                infl_valid;
    lq_idx_t             infl_slot;
    lq_idx_t             sel;

    // stores still ahead of each load
    sq_count_t older    [LQ_DEPTH];
    funct3_t   f3_mem   [LQ_DEPTH];
    rob_idx_t  rob_mem  [LQ_DEPTH];
    phys_reg_t pd_mem   [LQ_DEPTH];
    arch_reg_t rd_mem   [LQ_DEPTH];
    word_t     addr_mem [LQ_DEPTH];

    // lowest free slot and lowest ready slot
    always_comb
    begin
        ld_slot = '0;
        ld_full = 1'b1;
        sel     = '0;
        for (int i = LQ_DEPTH - 1; i >= 0; i--)
        begin
            ready[i] = valid[i] && addr_rdy[i] && (older[i] == '0)
                       && !(infl_valid && (infl_slot == lq_idx_t'(i)));
            if (!valid[i])
            begin
                ld_slot = lq_idx_t'(i);
                ld_full = 1'b0;
            end
            if (ready[i])
                sel = lq_idx_t'(i);
        end
    end

    assign ld_req  = |ready;
    assign ld_addr = addr_mem[sel];

    always_comb
    begin
        case (f3_mem[sel])
            F3_LB, F3_LBU: ld_rmask = 4'b0001 << ld_addr[1:0];
            F3_LH, F3_LHU: ld_rmask = 4'b0011 << {ld_addr[1], 1'b0};
            F3_LW:         ld_rmask = 4'b1111;
            default:       ld_rmask = 4'b0000;
        endcase
    end

    assign ld_done_rob = rob_mem[infl_slot];
    assign ld_done_pd  = pd_mem[infl_slot];
    assign ld_done_rd  = rd_mem[infl_slot];

    load_result_format u_format (
        .funct3 (f3_mem[infl_slot]),
        .offset (addr_mem[infl_slot][1:0]),
        .raw    (d_rdata),
        .value  (ld_value)
    );

    always_ff @(posedge clk)
    begin
        if (rst || flush)
        begin
            valid      <= '0;
            addr_rdy   <= '0;
            infl_valid <= 1'b0;
            infl_slot  <= '0;
        end
        else
        begin
            if (ld_dispatch && !ld_full)
            begin
                valid[ld_slot]    <= 1'b1;
                addr_rdy[ld_slot] <= 1'b0;
            end
            if (addr_valid && !addr_is_store)
                addr_rdy[slot] <= 1'b1;
            if (ld_grant)
            begin
                infl_valid <= 1'b1;
                infl_slot  <= sel;
            end
            if (ld_done)
            begin
                valid[infl_slot] <= 1'b0;
                infl_valid       <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk)
    begin
        for (int i = 0; i < LQ_DEPTH; i++)
        begin
            if (st_done && (older[i] != '0))
                older[i] <= older[i] - 1'b1;
        end
        if (ld_dispatch && !ld_full)
        begin
            // a store leaving this cycle is no longer ahead
            older[ld_slot]   <= st_count - sq_count_t'(st_done);
            f3_mem[ld_slot]  <= funct3;
            rob_mem[ld_slot] <= rob_idx;
            pd_mem[ld_slot]  <= pd;
            rd_mem[ld_slot]  <= rd;
        end
        if (addr_valid && !addr_is_store)
            addr_mem[slot] <= addr;
    end

endmodule : load_queue

//--- verilog/dcache_arbiter.sv
module dcache_arbiter
    import lsq_isa_pkg::*;
    import lsq_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       ld_req,
    input  word_t      ld_addr,
    input  byte_mask_t ld_rmask,
    input  logic       st_req,
    input  word_t      st_addr,
    input  byte_mask_t st_wmask,
    input  word_t      st_wdata,
    input  logic       data_valid,
    input  rob_idx_t   ld_done_rob,
    input  phys_reg_t  ld_done_pd,
    input  arch_reg_t  ld_done_rd,
    input  word_t      ld_value,
    input  rob_idx_t   st_done_rob,
    output logic       ld_grant,
    output logic       st_grant,
    output logic       ld_done,
    output logic       st_done,
    output word_t      d_addr,
    output byte_mask_t d_rmask,
    output byte_mask_t d_wmask,
    output word_t      d_wdata,
    output logic       result_valid,
    output rob_idx_t   result_rob,
    output phys_reg_t  result_pd,
    output arch_reg_t  result_rd,
    output word_t      result_value
);

    typedef enum logic {arb_idle, arb_busy} arb_state_t;

    arb_state_t state;
    // high means stores win a tie
    logic       prio_st;
    logic       owner_st;
    logic       discard;
    logic       resp;

    assign ld_grant = (state == arb_idle) && !flush && ld_req && (!st_req || !prio_st);
    assign st_grant = (state == arb_idle) && !flush && st_req && (!ld_req || prio_st);

    // request fields live only in the grant cycle
    assign d_addr  = st_grant ? {st_addr[31:2], 2'b00} :
                     ld_grant ? {ld_addr[31:2], 2'b00} : '0;
    assign d_rmask = ld_grant ? ld_rmask : '0;
    assign d_wmask = st_grant ? st_wmask : '0;
    assign d_wdata = st_grant ? st_wdata : '0;

    assign resp    = (state == arb_busy) && data_valid && !discard && !flush;
    assign ld_done = resp && !owner_st;
    assign st_done = resp && owner_st;

    assign result_valid = resp;
    assign result_rob   = owner_st ? st_done_rob : ld_done_rob;
    assign result_pd    = owner_st ? '0 : ld_done_pd;
    assign result_rd    = owner_st ? '0 : ld_done_rd;
    assign result_value = owner_st ? '0 : ld_value;

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state    <= arb_idle;
            prio_st  <= 1'b0;
            owner_st <= 1'b0;
            discard  <= 1'b0;
        end
        else
        begin
            case (state)
                arb_idle:
                begin
                    if (ld_grant || st_grant)
                    begin
                        state    <= arb_busy;
                        owner_st <= st_grant;
                        prio_st  <= !prio_st;
                    end
                end
                arb_busy:
                begin
                    if (data_valid)
                    begin
                        state   <= arb_idle;
                        discard <= 1'b0;
                    end
                    else if (flush)
                        discard <= 1'b1;
                end
                default: state <= arb_idle;
            endcase
        end
    end

endmodule : dcache_arbiter

//--- verilog/split_lsq.sv
module split_lsq
    import lsq_isa_pkg::*;
    import lsq_cfg_pkg::*;
(
    input  logic       clk,
    input  logic       rst,
    input  logic       flush,
    input  logic       ld_dispatch,
    input  logic       st_dispatch,
    input  funct3_t    funct3,
    input  rob_idx_t   rob_idx,
    input  phys_reg_t  pd,
    input  arch_reg_t  rd,
    input  logic       addr_valid,
    input  logic       addr_is_store,
    input  sq_idx_t    slot,
    input  word_t      addr,
    input  word_t      wdata,
    input  rob_idx_t   commit_rob,
    input  logic       data_valid,
    input  word_t      d_rdata,
    output lq_idx_t    ld_slot,
    output sq_idx_t    st_slot,
    output logic       full,
    output word_t      d_addr,
    output byte_mask_t d_rmask,
    output byte_mask_t d_wmask,
    output word_t      d_wdata,
    output logic       result_valid,
    output rob_idx_t   result_rob,
    output phys_reg_t  result_pd,
    output arch_reg_t  result_rd,
    output word_t      result_value
);

    sq_count_t  st_count;
    logic       st_full, st_req, st_grant, st_done;
    word_t      st_addr, st_wdata;
    byte_mask_t st_wmask;
    rob_idx_t   st_done_rob;

    logic       ld_full, ld_req, ld_grant, ld_done;
    word_t      ld_addr, ld_value;
    byte_mask_t ld_rmask;
    rob_idx_t   ld_done_rob;
    phys_reg_t  ld_done_pd;
    arch_reg_t  ld_done_rd;

    assign full = st_full | ld_full;

    store_queue u_sq (
        .clk, .rst, .flush, .st_dispatch, .funct3, .rob_idx,
        .addr_valid, .addr_is_store, .slot, .addr, .wdata, .commit_rob,
        .st_grant, .st_done, .st_slot, .st_count, .st_full, .st_req,
        .st_addr, .st_wmask, .st_wdata, .st_done_rob
    );

    load_queue u_lq (
        .clk, .rst, .flush, .ld_dispatch, .funct3, .rob_idx, .pd, .rd,
        .st_count, .addr_valid, .addr_is_store, .slot, .addr,
        .ld_grant, .ld_done, .st_done, .d_rdata, .ld_slot, .ld_full,
        .ld_req, .ld_addr, .ld_rmask, .ld_done_rob, .ld_done_pd,
        .ld_done_rd, .ld_value
    );

    dcache_arbiter u_arb (
        .clk, .rst, .flush, .ld_req, .ld_addr, .ld_rmask,
        .st_req, .st_addr, .st_wmask, .st_wdata, .data_valid,
        .ld_done_rob, .ld_done_pd, .ld_done_rd, .ld_value, .st_done_rob,
        .ld_grant, .st_grant, .ld_done, .st_done,
        .d_addr, .d_rmask, .d_wmask, .d_wdata,
        .result_valid, .result_rob, .result_pd, .result_rd, .result_value
    );

endmodule : split_lsq

//--- sim/tb_clock_gen.sv
module tb_clock_gen
(
    output logic clk,
    output logic rst
);

    timeunit 1ns;
    timeprecision 1ps;

    // 40 ns period
    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for ten rising edges, released on a falling edge
    initial
    begin
        rst = 1'b1;
        repeat (10) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule : tb_clock_gen

//--- sim/split_lsq_tb.sv
module split_lsq_tb
    import lsq_isa_pkg::*;
    import lsq_cfg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int     N_OPS   = 22;
    localparam int     TIMEOUT = 60;
    localparam integer SEED    = 32'hdb809ff8;

    typedef struct packed {
        logic      is_store;
        funct3_t   f3;
        rob_idx_t  rob;
        phys_reg_t pd;
        arch_reg_t rd;
        word_t     addr;
        word_t     wdata;
        word_t     exp_value;
    } op_t;

    // kind, funct3, rob, pd, rd, address, write data, expected result value
    localparam op_t OPS [N_OPS] = '{
        '{1'b1, F3_SW,  5'd0,  6'd0,  5'd0,  32'h10, 32'h80F17F22, 32'h00000000},
        '{1'b0, F3_LB,  5'd1,  6'd33, 5'd1,  32'h10, 32'h0,        32'h00000022},
        '{1'b0, F3_LB,  5'd2,  6'd34, 5'd2,  32'h11, 32'h0,        32'h0000007F},
        '{1'b0, F3_LB,  5'd3,  6'd35, 5'd3,  32'h12, 32'h0,        32'hFFFFFFF1},
        '{1'b0, F3_LB,  5'd4,  6'd36, 5'd4,  32'h13, 32'h0,        32'hFFFFFF80},
        '{1'b0, F3_LBU, 5'd5,  6'd37, 5'd5,  32'h10, 32'h0,        32'h00000022},
        '{1'b0, F3_LBU, 5'd6,  6'd38, 5'd6,  32'h11, 32'h0,        32'h0000007F},
        '{1'b0, F3_LBU, 5'd7,  6'd39, 5'd7,  32'h12, 32'h0,        32'h000000F1},
        '{1'b0, F3_LBU, 5'd8,  6'd40, 5'd8,  32'h13, 32'h0,        32'h00000080},
        '{1'b0, F3_LH,  5'd9,  6'd41, 5'd9,  32'h10, 32'h0,        32'h00007F22},
        '{1'b0, F3_LH,  5'd10, 6'd42, 5'd10, 32'h12, 32'h0,        32'hFFFF80F1},
        '{1'b0, F3_LHU, 5'd11, 6'd43, 5'd11, 32'h10, 32'h0,        32'h00007F22},
        '{1'b0, F3_LHU, 5'd12, 6'd44, 5'd12, 32'h12, 32'h0,        32'h000080F1},
        '{1'b0, F3_LW,  5'd13, 6'd45, 5'd13, 32'h10, 32'h0,        32'h80F17F22},
        '{1'b1, F3_SW,  5'd14, 6'd0,  5'd0,  32'h18, 32'h11223344, 32'h00000000},
        '{1'b1, F3_SB,  5'd15, 6'd0,  5'd0,  32'h19, 32'hDEADBEA5, 32'h00000000},
        '{1'b1, F3_SH,  5'd16, 6'd0,  5'd0,  32'h1A, 32'h5555C3D2, 32'h00000000},
        '{1'b1, F3_SB,  5'd17, 6'd0,  5'd0,  32'h18, 32'h0000007E, 32'h00000000},
        '{1'b0, F3_LW,  5'd18, 6'd50, 5'd18, 32'h18, 32'h0,        32'hC3D2A57E},
        '{1'b0, F3_LH,  5'd19, 6'd51, 5'd19, 32'h1A, 32'h0,        32'hFFFFC3D2},
        // rows run after the flush
        '{1'b1, F3_SW,  5'd25, 6'd0,  5'd0,  32'h0C, 32'h0BADCAFE, 32'h00000000},
        '{1'b0, F3_LHU, 5'd26, 6'd52, 5'd20, 32'h0E, 32'h0,        32'h00000BAD}
    };

    logic       clk;
    logic       rst;
    logic       flush;
    logic       ld_dispatch;
    logic       st_dispatch;
    funct3_t    funct3;
    rob_idx_t   rob_idx;
    phys_reg_t  pd;
    arch_reg_t  rd;
    logic       addr_valid;
    logic       addr_is_store;
    sq_idx_t    slot;
    word_t      addr;
    word_t      wdata;
    rob_idx_t   commit_rob;
    logic       data_valid = 1'b0;
    word_t      d_rdata = '0;
    lq_idx_t    ld_slot;
    sq_idx_t    st_slot;
    logic       full;
    word_t      d_addr;
    byte_mask_t d_rmask;
    byte_mask_t d_wmask;
    word_t      d_wdata;
    logic       result_valid;
    rob_idx_t   result_rob;
    phys_reg_t  result_pd;
    arch_reg_t  result_rd;
    word_t      result_value;

    // dcache model state
    word_t      dmem [16];
    integer     seed = SEED;
    int         req_count = 0;
    int         resp_count = 0;
    logic       pend = 1'b0;
    int         wait_cnt;
    word_t      rd_word;
    byte_mask_t wr_mask;
    word_t      wr_data;
    logic [3:0] widx;

    tb_clock_gen u_clk (.clk, .rst);

    split_lsq uut (.*);

    task automatic fail_stop();
        $display("Something failed");
        $fatal(1, "simulation stopped at the first error");
    endtask

    task automatic check_result(rob_idx_t exp_rob, phys_reg_t exp_pd, arch_reg_t exp_rd,
                                word_t exp_value);
        if (result_rob !== exp_rob)
        begin
            $display("ERR %0t: result rob %0d, expected %0d", $time, result_rob, exp_rob);
            fail_stop();
        end
        if (result_pd !== exp_pd || result_rd !== exp_rd)
        begin
            $display("ERR %0t: rob %0d pd %0d rd %0d, expected pd %0d rd %0d", $time,
                     exp_rob, result_pd, result_rd, exp_pd, exp_rd);
            fail_stop();
        end
        if (result_value !== exp_value)
        begin
            $display("ERR %0t: rob %0d value %h, expected %h", $time, exp_rob,
                     result_value, exp_value);
            fail_stop();
        end
    endtask

    task automatic check_store_access(byte_mask_t exp_mask, word_t exp_data);
        if (wr_mask !== exp_mask || wr_data !== exp_data)
        begin
            $display("ERR %0t: store wmask %b wdata %h, expected %b %h", $time,
                     wr_mask, wr_data, exp_mask, exp_data);
            fail_stop();
        end
    endtask

    task automatic check_flag(logic got, logic exp, string what);
        if (got !== exp)
        begin
            $display("ERR %0t: %s is %b, expected %b", $time, what, got, exp);
            fail_stop();
        end
    endtask

    // byte lanes a store of this width touches
    function automatic byte_mask_t lanes_for(funct3_t f3, logic [1:0] off);
        int         n;
        byte_mask_t m;
        n = (f3 == F3_SW) ? 4 : (f3 == F3_SH) ? 2 : 1;
        m = '0;
        for (int b = 0; b < n; b++)
            m[int'(off) + b] = 1'b1;
        return m;
    endfunction

    function automatic word_t place_data(funct3_t f3, logic [1:0] off, word_t data);
        byte_mask_t m;
        word_t      w;
        m = lanes_for(f3, off);
        w = '0;
        for (int b = 0; b < 4; b++)
        begin
            if (m[b])
                w[8*b +: 8] = data[8*(b - int'(off)) +: 8];
        end
        return w;
    endfunction

    initial
    begin
        for (int i = 0; i < 16; i++)
            dmem[i] = 32'h9e3779b9 * (i + 1);
    end

    // requests are seen on the rising edge
    always @(posedge clk)
    begin
        if (d_rmask != '0 || d_wmask != '0)
        begin
            if (pend || (d_rmask != '0 && d_wmask != '0) || d_addr[1:0] != 2'b00)
            begin
                $display("ERR %0t: bad dcache request addr %h rmask %b wmask %b", $time,
                         d_addr, d_rmask, d_wmask);
                fail_stop();
            end
            widx = d_addr[5:2];
            for (int b = 0; b < 4; b++)
            begin
                if (d_wmask[b])
                    dmem[widx][8*b +: 8] = d_wdata[8*b +: 8];
            end
            rd_word   = dmem[widx];
            wr_mask   = d_wmask;
            wr_data   = d_wdata;
            wait_cnt  = {$random(seed)} % 4;
            pend      = 1'b1;
            req_count = req_count + 1;
        end
    end

    // answers 1 to 4 cycles later on a falling edge
    always @(negedge clk)
    begin
        data_valid = 1'b0;
        d_rdata    = '0;
        if (pend)
        begin
            if (wait_cnt == 0)
            begin
                data_valid = 1'b1;
                d_rdata    = rd_word;
                pend       = 1'b0;
                resp_count = resp_count + 1;
            end
            else
                wait_cnt = wait_cnt - 1;
        end
    end

    // entered and left on a falling edge
    task automatic dispatch_op(logic is_store, funct3_t f3, rob_idx_t rob, phys_reg_t p,
                               arch_reg_t r, output sq_idx_t got_slot);
        ld_dispatch = !is_store;
        st_dispatch = is_store;
        funct3      = f3;
        rob_idx     = rob;
        pd          = p;
        rd          = r;
        got_slot    = is_store ? st_slot : ld_slot;
        @(negedge clk);
        ld_dispatch = 1'b0;
        st_dispatch = 1'b0;
    endtask

    task automatic give_address(logic is_store, sq_idx_t s, word_t a, word_t d);
        addr_valid    = 1'b1;
        addr_is_store = is_store;
        slot          = s;
        addr          = a;
        wdata         = d;
        @(negedge clk);
        addr_valid = 1'b0;
    endtask

    task automatic wait_result();
        int n;
        n = 0;
        @(posedge clk);
        while (!result_valid)
        begin
            n++;
            if (n > TIMEOUT)
            begin
                $display("no result arrived within %0d cycles", TIMEOUT);
                fail_stop();
            end
            @(posedge clk);
        end
    endtask

    task automatic apply_row(op_t op);
        sq_idx_t s;
        int      reqs;
        // an older instruction is still committing
        if (op.is_store)
            commit_rob = op.rob - 1'b1;
        dispatch_op(op.is_store, op.f3, op.rob, op.pd, op.rd, s);
        give_address(op.is_store, s, op.addr, op.wdata);
        if (op.is_store)
        begin
            reqs = req_count;
            repeat (3) @(negedge clk);
            if (req_count != reqs)
            begin
                $display("a store reached the dcache before it was committing");
                fail_stop();
            end
            commit_rob = op.rob;
        end
        wait_result();
        check_result(op.rob, op.pd, op.rd, op.exp_value);
        if (op.is_store)
            check_store_access(lanes_for(op.f3, op.addr[1:0]),
                               place_data(op.f3, op.addr[1:0], op.wdata));
        @(negedge clk);
        commit_rob = op.rob + 1'b1;
    endtask

    task automatic run_rows(int first, int last);
        for (int i = first; i <= last; i++)
            apply_row(OPS[i]);
    endtask

    task automatic store_then_load();
        sq_idx_t s;
        int      reqs;
        reqs       = req_count;
        commit_rob = 5'd9;
        dispatch_op(1'b1, F3_SW, 5'd10, '0, '0, s);
        give_address(1'b1, s, 32'h08, 32'h600DF00D);
        dispatch_op(1'b0, F3_LW, 5'd11, 6'd33, 5'd7, s);
        give_address(1'b0, s, 32'h08, '0);
        repeat (4) @(negedge clk);
        if (req_count != reqs)
        begin
            $display("the load went to the dcache ahead of an older store");
            fail_stop();
        end
        commit_rob = 5'd10;
        wait_result();
        check_result(5'd10, '0, '0, '0);
        check_store_access(4'b1111, 32'h600DF00D);
        @(negedge clk);
        commit_rob = 5'd11;
        wait_result();
        check_result(5'd11, 6'd33, 5'd7, 32'h600DF00D);
        @(negedge clk);
    endtask

    task automatic fill_store_queue();
        sq_idx_t s;
        commit_rob = 5'd15;
        for (int i = 0; i < SQ_DEPTH; i++)
        begin
            check_flag(full, 1'b0, "full before the store queue filled");
            dispatch_op(1'b1, F3_SW, rob_idx_t'(16 + i), '0, '0, s);
            give_address(1'b1, s, 32'h20 + 4 * i, 32'hA000_0000 + i);
        end
        check_flag(full, 1'b1, "full with every store slot taken");
        commit_rob = 5'd16;
        wait_result();
        check_result(5'd16, '0, '0, '0);
        check_store_access(4'b1111, 32'hA000_0000);
        @(negedge clk);
        check_flag(full, 1'b0, "full after one store left");
    endtask

    task automatic flush_outstanding_load();
        sq_idx_t s;
        int      n;
        int      reqs;
        logic    idle_now;
        // drop the stores still waiting for commit
        flush = 1'b1;
        @(negedge clk);
        flush = 1'b0;
        reqs  = req_count;
        dispatch_op(1'b0, F3_LW, 5'd24, 6'd60, 5'd12, s);
        give_address(1'b0, s, 32'h04, '0);
        n = 0;
        while (req_count == reqs)
        begin
            n++;
            if (n > TIMEOUT)
            begin
                $display("the load never reached the dcache");
                fail_stop();
            end
            @(negedge clk);
        end
        flush    = 1'b1;
        idle_now = 1'b0;
        n        = 0;
        while (!idle_now)
        begin
            @(posedge clk);
            check_flag(result_valid, 1'b0, "result_valid for a flushed load");
            idle_now = (resp_count == req_count);
            @(negedge clk);
            flush = 1'b0;
            n++;
            if (n > TIMEOUT)
            begin
                $display("the flushed load was never answered by the dcache");
                fail_stop();
            end
        end
    endtask

    initial
    begin
        int n;
        flush         = 1'b0;
        ld_dispatch   = 1'b0;
        st_dispatch   = 1'b0;
        funct3        = '0;
        rob_idx       = '0;
        pd            = '0;
        rd            = '0;
        addr_valid    = 1'b0;
        addr_is_store = 1'b0;
        slot          = '0;
        addr          = '0;
        wdata         = '0;
        commit_rob    = '0;
        n             = 0;
        @(posedge clk);
        while (rst)
        begin
            n++;
            if (n > TIMEOUT)
            begin
                $display("reset was never released");
                fail_stop();
            end
            @(posedge clk);
        end
        check_flag(full, 1'b0, "full after reset");
        check_flag(result_valid, 1'b0, "result_valid after reset");
        check_flag(d_rmask != '0 || d_wmask != '0, 1'b0, "a dcache mask after reset");
        @(negedge clk);

        store_then_load();
        run_rows(0, 19);
        fill_store_queue();
        flush_outstanding_load();
        run_rows(20, 21);

        $display("Everything OK");
        $finish;
    end

endmodule : split_lsq_tb

//--- vlog.f
verilog/lsq_isa_pkg.sv
verilog/lsq_cfg_pkg.sv
verilog/load_result_format.sv
verilog/store_queue.sv
verilog/load_queue.sv
verilog/dcache_arbiter.sv
verilog/split_lsq.sv
sim/tb_clock_gen.sv
sim/split_lsq_tb.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --timescale 1ns/1ps -Wno-fatal \
    --top-module split_lsq_tb -f vlog.f || exit 1
out=$(./obj_dir/Vsplit_lsq_tb 2>&1)
echo "$out"
echo "$out" | grep -qx "Everything OK" && exit 0 || exit 1
